/* bench/vmpeg_tb_tasks.svh */
`ifndef VMPEG_TB_TASKS_SVH
`define VMPEG_TB_TASKS_SVH

// Reference model state
integer      seed = 40009;
logic [15:0] exp_fma_ier;
logic [15:0] exp_fmv_ier;
logic [15:0] exp_fma_ivec;
logic [15:0] exp_fmv_ivec;
logic [15:0] exp_tcnt;
fma_irq_t    exp_fma_flags;
fmv_irq_t    exp_fmv_flags;
fma_irq_t    exp_fma_stat;     // FMA status register
logic        vsync_prev;
logic [31:0] exp_ticks;        // Decoder clock
int          ticks_since_fire;

task automatic reset_model();
    exp_fma_ier      = '0;
    exp_fmv_ier      = '0;
    exp_fma_ivec     = '0;
    exp_fmv_ivec     = '0;
    exp_tcnt         = `VMPEG_TCNT_RESET;
    exp_fma_flags    = '0;
    exp_fmv_flags    = '0;
    exp_fma_stat     = '0;
    vsync_prev       = 1'b0;
    exp_ticks        = '0;
    ticks_since_fire = 0;
endtask

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (actual !== expected) begin
        $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
        $display("Simulation finished: FAIL");
        $fatal(1, "Value mismatch in %s", name);
    end
endtask

// One CPU cycle with cs held until bus_ack has been seen
task automatic bus_access(input logic write, input logic [14:0] addr,
                          input logic [15:0] wdata, output logic [15:0] rdata);
    @(negedge clk);
    bus.address      = {8'd0, addr};
    bus.data         = wdata;
    bus.uds          = 1'b1;
    bus.lds          = 1'b1;
    bus.write_strobe = write;
    bus.cs           = 1'b1;
    @(negedge clk);
    while (!bus_ack) @(negedge clk);
    rdata = dout;                  // Write or ISR clear lands on the next edge
    @(negedge clk);
    bus.cs           = 1'b0;
    bus.uds          = 1'b0;
    bus.lds          = 1'b0;
    bus.write_strobe = 1'b0;
endtask

task automatic bus_write(input logic [14:0] addr, input logic [15:0] wdata);
    logic [15:0] unused_rdata;
    bus_access(1'b1, addr, wdata, unused_rdata);
endtask

task automatic read_check(input string name, input logic [14:0] addr,
                          input logic [15:0] expected);
    logic [15:0] rdata;
    bus_access(1'b0, addr, 16'h0000, rdata);
    check_value(name, expected, rdata);
endtask

task automatic write_random(input string name, input logic [14:0] addr,
                            output logic [15:0] value);
    value = 16'($random(seed));
    bus_write(addr, value);
    read_check(name, addr, value);
endtask

task automatic note_events(input decoder_events_t ev, input logic vs);
    exp_fma_flags.dec   |= ev.fma_decoding_started;
    exp_fma_flags.upd   |= ev.fma_frame_decoded;
    exp_fma_flags.unf   |= ev.fma_underflow;
    exp_fma_flags.eoi   |= ev.fma_program_end;
    exp_fmv_flags.seq   |= ev.fmv_first_intra;     // Headers come with the first I picture
    exp_fmv_flags.gop   |= ev.fmv_first_intra;
    exp_fmv_flags.pic   |= ev.fmv_picture;
    exp_fmv_flags.eod   |= ev.fmv_last_picture;
    exp_fmv_flags.eii   |= ev.fmv_program_end;
    exp_fmv_flags.esi   |= ev.fmv_sequence_end;
    exp_fmv_flags.ndat  |= ev.fmv_underflow;
    exp_fmv_flags.vsync |= vs && !vsync_prev;
    vsync_prev = vs;
    if (ev.fma_decoding_started) exp_fma_stat.dec = 1'b1;
    if (ev.fma_frame_decoded) begin
        exp_fma_stat.dec = 1'b0;
        exp_fma_stat.upd = 1'b1;
    end
    exp_fma_stat.unf |= ev.fma_underflow;
    exp_fma_stat.eoi |= ev.fma_program_end;
endtask

// Timer period is 8*tcnt+1 ticks
task automatic note_tick();
    exp_ticks = exp_ticks + 32'd1;
    ticks_since_fire++;
    if (ticks_since_fire == 8 * int'(exp_tcnt) + 1) begin
        ticks_since_fire   = 0;
        exp_fmv_flags.tim  = 1'b1;
        exp_fma_flags.poll = 1'b1;
    end
endtask

function automatic logic expected_intreq();
    return (|(exp_fma_flags & exp_fma_ier)) || (|(exp_fmv_flags & exp_fmv_ier));
endfunction

function automatic logic [15:0] ack_vector();
    if (|(exp_fma_flags & exp_fma_ier)) begin
        return {exp_fma_ivec[7:0], exp_fma_ivec[7:0]};
    end else begin
        return {exp_fmv_ivec[10:3], exp_fmv_ivec[10:3]};
    end
endfunction

`endif

/* bench/vmpeg_tb.sv */
`include "vmpeg_settings.svh"

module vmpeg_tb
    import vmpeg_pkg::*;
();
    localparam int TICKS = 300;
    // Covers roughly 200 bus cycles, 300 ticks and 80 DMA words with wide margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic            clk;
    logic            reset;
    bus_req_t        bus;
    logic [15:0]     dout;
    logic            bus_ack;
    logic            intack;
    logic            intreq;
    logic            req;
    logic            rdy;
    logic            ack;
    logic            dtc;
    logic            done_in;
    logic            vsync;
    logic            clk45tick;
    decoder_events_t events;
    mpeg_byte_t      mpeg_byte;
    logic            fma_decoder_enable;
    logic            fma_fifo_reset;
    logic            fmv_decoder_enable;
    logic            fmv_playback_active;
    logic            fmv_fifo_reset;

    int          cycle_count = 0;
    int          fma_fifo_pulses = 0;
    int          fmv_fifo_pulses = 0;
    int          pulses;
    logic [31:0] r;
    logic [15:0] value;

    `include "vmpeg_tb_tasks.svh"

    vmpeg_top vmpeg_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $fatal(1, "Timeout");
        end
    end

    always @(negedge clk) begin
        if (fma_fifo_reset) fma_fifo_pulses++;
        if (fmv_fifo_reset) fmv_fifo_pulses++;
    end

    task automatic pulse_events(input decoder_events_t ev, input logic vs);
        @(negedge clk);
        events = ev;
        vsync  = vs;
        note_events(ev, vs);
        @(negedge clk);
        events = '0;
    endtask

    // Words over ack/dtc split into high then low byte
    task automatic dma_stream(input logic to_fma, input int words);
        logic [15:0] word;
        logic        back;
        if (to_fma) bus_write(`VMPEG_FMA_CMD, 16'h8002);
        else bus_write(`VMPEG_FMV_SYSCMD, 16'h8000);
        check_value("dma_start", 2'b11, {req, rdy});
        for (int k = 0; k < words; k++) begin
            word = 16'($random(seed));
            back = (k != words - 1) && (($random(seed) & 3) == 0);
            @(negedge clk);
            bus.data = word;
            ack      = 1'b1;
            dtc      = 1'b1;
            #10;
            check_value("high_byte", {word[15:8], !to_fma, to_fma}, mpeg_byte);
            if (!back) begin                 // Back-to-back words drop the low byte
                @(negedge clk);
                ack = 1'b0;
                dtc = 1'b0;
                #10;
                check_value("low_byte", {word[7:0], !to_fma, to_fma}, mpeg_byte);
                @(negedge clk);
                #10;
                check_value("byte_idle", 2'b00, {mpeg_byte.fmv_valid, mpeg_byte.fma_valid});
            end
        end
        @(negedge clk);
        ack     = 1'b1;
        done_in = 1'b1;
        @(negedge clk);
        ack     = 1'b0;
        done_in = 1'b0;
        #10;
        check_value("dma_done", 2'b00, {req, rdy});
    endtask

    initial begin
        reset     = 1'b1;
        bus       = '0;
        intack    = 1'b0;
        ack       = 1'b0;
        dtc       = 1'b0;
        done_in   = 1'b0;
        vsync     = 1'b0;
        clk45tick = 1'b0;
        events    = '0;
        reset_model();
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_value("reset_outputs", 9'd0, {req, rdy, bus_ack, intreq, fma_decoder_enable,
                    fmv_decoder_enable, fmv_playback_active, fma_fifo_reset, fmv_fifo_reset});

        // Register readback
        read_check("tcnt_reset", `VMPEG_FMV_TCNT, `VMPEG_TCNT_RESET);
        repeat (6) begin
            write_random("fma_ier", `VMPEG_FMA_IER, exp_fma_ier);
            write_random("fmv_ier", `VMPEG_FMV_IER, exp_fmv_ier);
            write_random("fma_ivec", `VMPEG_FMA_IVEC, exp_fma_ivec);
            write_random("fmv_ivec", `VMPEG_FMV_IVEC, exp_fmv_ivec);
            write_random("tcnt", `VMPEG_FMV_TCNT, exp_tcnt);
            write_random("frame_rate", `VMPEG_FMV_FRAME_RATE, value);
        end
        read_check("hf2", `VMPEG_RO_HF2_ADDR, `VMPEG_RO_HF2);
        read_check("pic_rate", `VMPEG_RO_PIC_RATE_ADDR, `VMPEG_RO_PIC_RATE);
        read_check("disp_rate", `VMPEG_RO_DISP_RATE_ADDR, `VMPEG_RO_DISP_RATE);
        read_check("sts", `VMPEG_RO_STS_ADDR, `VMPEG_RO_STS);
        read_check("unmapped", 15'h1234, 16'h0000);
        check_value("intreq_idle", 1'b0, intreq);

        // Interrupt flags from events and vsync edges
        for (int i = 0; i < 80; i++) begin
            r = $random(seed);
            pulse_events(r[9:0] & r[19:10], r[20]);
            check_value("intreq", expected_intreq(), intreq);
            if (r[23:21] == 3'd0) begin
                read_check("fma_isr", `VMPEG_FMA_ISR, exp_fma_flags);
                exp_fma_flags = '0;
            end
            if (r[26:24] == 3'd0) begin
                read_check("fmv_isr", `VMPEG_FMV_ISR, exp_fmv_flags);
                exp_fmv_flags = '0;
            end
            if (r[28:27] == 2'd0) read_check("fma_stat", `VMPEG_FMA_STAT, exp_fma_stat);
            if (r[31:29] == 3'd0) begin
                write_random("fma_ier", `VMPEG_FMA_IER, exp_fma_ier);
                write_random("fmv_ier", `VMPEG_FMV_IER, exp_fmv_ier);
            end
        end

        // Vectored acknowledge
        write_random("fma_ivec", `VMPEG_FMA_IVEC, exp_fma_ivec);
        write_random("fmv_ivec", `VMPEG_FMV_IVEC, exp_fmv_ivec);
        for (int i = 0; i < 8; i++) begin
            r = $random(seed);
            exp_fma_ier = r[0] ? 16'h0000 : r[31:16];
            bus_write(`VMPEG_FMA_IER, exp_fma_ier);
            pulse_events(r[9:0], vsync);
            @(negedge clk);
            intack = 1'b1;
            @(negedge clk);
            check_value("ack_vector", ack_vector(), dout);
            intack = 1'b0;
        end

        // DMA stream to each target
        dma_stream(1'b0, 40);
        dma_stream(1'b1, 40);
        read_check("fma_cmd_after_dma", `VMPEG_FMA_CMD, 16'h0002);

        // CPU word over XFER goes to the last DMA target
        value = 16'($random(seed));
        bus_write(`VMPEG_FMV_XFER, value);
        #10;
        check_value("xfer_low_byte", {value[7:0], 2'b01}, mpeg_byte);

        // Timebase
        r = $random(seed);
        exp_tcnt = {14'd0, r[1:0]} + 16'd3;
        bus_write(`VMPEG_FMV_TCNT, exp_tcnt);
        exp_fma_ier = 16'h0000;
        bus_write(`VMPEG_FMA_IER, exp_fma_ier);
        exp_fmv_ier = 16'h0100;                   // tim only
        bus_write(`VMPEG_FMV_IER, exp_fmv_ier);
        read_check("fma_isr_clear", `VMPEG_FMA_ISR, exp_fma_flags);
        exp_fma_flags = '0;
        read_check("fmv_isr_clear", `VMPEG_FMV_ISR, exp_fmv_flags);
        exp_fmv_flags = '0;
        bus_write(`VMPEG_FMV_TRLD, 16'h0000);
        ticks_since_fire = 0;
        for (int i = 0; i < TICKS; i++) begin
            r = $random(seed);
            @(negedge clk);
            clk45tick = 1'b1;
            note_tick();
            @(negedge clk);
            clk45tick = 1'b0;
            check_value("timer_intreq", expected_intreq(), intreq);
            if (exp_fmv_flags.tim) begin
                read_check("fmv_isr_tim", `VMPEG_FMV_ISR, exp_fmv_flags);
                exp_fmv_flags = '0;
            end
            if (i == TICKS / 2) begin
                bus_write(`VMPEG_FMV_TRLD, 16'h0000);   // Re-arm mid run
                ticks_since_fire = 0;
            end
            repeat (r[1:0]) @(negedge clk);
        end
        read_check("fma_isr_poll", `VMPEG_FMA_ISR, exp_fma_flags);
        exp_fma_flags = '0;
        read_check("dclkh", `VMPEG_FMA_DCLKH, exp_ticks[31:16]);
        read_check("dclkl", `VMPEG_FMA_DCLKL, exp_ticks[15:0]);

        // Commands
        bus_write(`VMPEG_FMV_SYSCMD, 16'h1000);
        check_value("decoder_on", 1'b1, fmv_decoder_enable);
        bus_write(`VMPEG_FMV_SYSCMD, 16'h0008);
        check_value("play", 1'b1, fmv_playback_active);
        bus_write(`VMPEG_FMV_SYSCMD, 16'h0010);
        exp_fmv_flags.pai = 1'b1;
        check_value("pause", 1'b0, fmv_playback_active);
        read_check("fmv_isr_pai", `VMPEG_FMV_ISR, exp_fmv_flags);
        exp_fmv_flags = '0;
        bus_write(`VMPEG_FMV_SYSCMD, 16'h0020);
        check_value("continue", 1'b1, fmv_playback_active);
        pulses = fmv_fifo_pulses;
        bus_write(`VMPEG_FMV_SYSCMD, 16'h0100);
        @(negedge clk);
        #10;
        check_value("clear_fifo_pulse", pulses + 1, fmv_fifo_pulses);
        check_value("clear_fifo_stop", 1'b0, fmv_playback_active);
        bus_write(`VMPEG_FMV_SYSCMD, 16'h0008);
        bus_write(`VMPEG_FMV_SYSCMD, 16'h2000);
        check_value("decoder_off", 2'b00, {fmv_decoder_enable, fmv_playback_active});
        bus_write(`VMPEG_FMA_CMD, 16'h0002);
        check_value("fma_start", 1'b1, fma_decoder_enable);
        pulses = fma_fifo_pulses;
        bus_write(`VMPEG_FMA_CMD, 16'h0001);
        bus_write(`VMPEG_FMA_CMD, 16'h0002);      // Stop sequence
        @(negedge clk);
        #10;
        check_value("fma_stop", 1'b0, fma_decoder_enable);
        check_value("fma_fifo_pulse", pulses + 1, fma_fifo_pulses);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build the VMPEG host testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module vmpeg_tb -f vlog.f -o vmpeg_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/vmpeg_sim; then
    echo "Simulation ended with an error status"
    exit 1
fi

exit 0

/* src/vmpeg_byte_splitter.sv */
module vmpeg_byte_splitter
    import vmpeg_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic [15:0] din,
    input  logic        ack,
    input  logic        dtc,
    input  logic        xfer_write,
    input  logic        dma_for_fma,
    output mpeg_byte_t  mpeg_byte
);
    wire word_valid = (ack && dtc) || xfer_write;   // DMA word or CPU XFER write

    logic       word_valid_q;
    logic [7:0] low_byte;

    always_ff @(posedge clk) begin
        if (reset) begin
            word_valid_q <= 1'b0;
        end else begin
            word_valid_q <= word_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (word_valid) low_byte <= din[7:0];
    end

    always_comb begin
        mpeg_byte.data      = word_valid ? din[15:8] : low_byte;   // High byte wins
        mpeg_byte.fma_valid = (word_valid || word_valid_q) && dma_for_fma;
        mpeg_byte.fmv_valid = (word_valid || word_valid_q) && !dma_for_fma;
    end

endmodule

/* src/vmpeg_host_ctrl.sv */
`include "vmpeg_settings.svh"

module vmpeg_host_ctrl
    import vmpeg_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  bus_req_t        bus,
    input  logic            ack,
    input  logic            done_in,
    input  logic            vsync,
    input  decoder_events_t events,
    input  logic            timer_fire,
    output logic            bus_ack,
    output irq_ctl_t        fma_irq_ctl,
    output irq_ctl_t        fmv_irq_ctl,
    output fma_irq_t        fma_set,
    output fmv_irq_t        fmv_set,
    output host_regs_t      regs,
    output logic            trld_clear,
    output logic            dclk_latch,
    output logic            xfer_write,
    output logic            dma_for_fma,
    output logic            fma_decoder_enable,
    output logic            fma_fifo_reset,
    output logic            fmv_fifo_reset
);
    wire access = bus.cs && (bus.uds || bus.lds);
    wire [`VMPEG_ADDR_W-1:0] addr = bus.address[`VMPEG_ADDR_W-1:0];
    wire [`VMPEG_DATA_W-1:0] wdata = bus.data;
    wire wr_en = access && bus.write_strobe && bus_ack;
    wire rd_en = access && !bus.write_strobe && bus_ack;
    wire fma_cmd_wr = wr_en && (addr == `VMPEG_FMA_CMD);
    wire syscmd_wr = wr_en && (addr == `VMPEG_FMV_SYSCMD);

    logic [15:0] fma_command;
    logic [15:0] fmv_timer_compare;
    logic [15:0] fmv_frame_rate;
    fma_irq_t    fma_status;
    logic        dma_active;
    logic        fmv_decoder_enable;
    logic        fmv_playback_active;
    logic        vsync_q;

    always_comb begin
        fma_irq_ctl.ier_write  = wr_en && (addr == `VMPEG_FMA_IER);
        fma_irq_ctl.ivec_write = wr_en && (addr == `VMPEG_FMA_IVEC);
        fma_irq_ctl.clear      = rd_en && (addr == `VMPEG_FMA_ISR);
        fmv_irq_ctl.ier_write  = wr_en && (addr == `VMPEG_FMV_IER);
        fmv_irq_ctl.ivec_write = wr_en && (addr == `VMPEG_FMV_IVEC);
        fmv_irq_ctl.clear      = rd_en && (addr == `VMPEG_FMV_ISR);

        fma_set      = '0;
        fma_set.eoi  = events.fma_program_end;
        fma_set.upd  = events.fma_frame_decoded;
        fma_set.unf  = events.fma_underflow;
        fma_set.dec  = events.fma_decoding_started;
        fma_set.poll = timer_fire;

        fmv_set       = '0;
        fmv_set.seq   = events.fmv_first_intra;   // Sequence and GOP headers come with it
        fmv_set.gop   = events.fmv_first_intra;
        fmv_set.pic   = events.fmv_picture;
        fmv_set.eod   = events.fmv_last_picture;
        fmv_set.eii   = events.fmv_program_end;
        fmv_set.esi   = events.fmv_sequence_end;
        fmv_set.ndat  = events.fmv_underflow;
        fmv_set.vsync = vsync && !vsync_q;
        fmv_set.tim   = timer_fire;
        fmv_set.pai   = syscmd_wr && wdata[4];

        regs.fma_command         = fma_command;
        regs.fma_status          = fma_status;
        regs.fmv_timer_compare   = fmv_timer_compare;
        regs.fmv_frame_rate      = fmv_frame_rate;
        regs.dma_active          = dma_active;
        regs.fmv_decoder_enable  = fmv_decoder_enable;
        regs.fmv_playback_active = fmv_playback_active;
    end

    assign trld_clear = wr_en && (addr == `VMPEG_FMV_TRLD);
    assign dclk_latch = rd_en && (addr == `VMPEG_FMA_DCLKH);
    assign xfer_write = wr_en && (addr == `VMPEG_FMV_XFER);

    always_ff @(posedge clk) begin
        if (reset) begin
            bus_ack             <= 1'b0;
            vsync_q             <= 1'b0;
            fma_command         <= '0;
            fma_status          <= '0;
            fmv_timer_compare   <= `VMPEG_TCNT_RESET;
            fmv_frame_rate      <= '0;
            dma_active          <= 1'b0;
            dma_for_fma         <= 1'b0;
            fma_decoder_enable  <= 1'b0;
            fmv_decoder_enable  <= 1'b0;
            fmv_playback_active <= 1'b0;
            fma_fifo_reset      <= 1'b0;
            fmv_fifo_reset      <= 1'b0;
        end else begin
            bus_ack        <= access && !bus_ack;   // Toggles during an access
            vsync_q        <= vsync;
            fma_fifo_reset <= 1'b0;
            fmv_fifo_reset <= 1'b0;

            // FMA status mirrors the events
            if (events.fma_decoding_started) fma_status.dec <= 1'b1;
            if (events.fma_frame_decoded) begin
                fma_status.dec <= 1'b0;
                fma_status.upd <= 1'b1;
            end
            if (events.fma_underflow) fma_status.unf <= 1'b1;
            if (events.fma_program_end) fma_status.eoi <= 1'b1;

            if (done_in && ack) begin
                dma_active      <= 1'b0;
                fma_command[15] <= 1'b0;
            end

            if (fma_cmd_wr) begin
                fma_command <= wdata;
                if (wdata[15]) begin
                    dma_active  <= 1'b1;
                    dma_for_fma <= 1'b1;
                end
                // 1 then 2 stops the decoder and a lone 2 starts it
                if (wdata == 16'd2) begin
                    fma_decoder_enable <= (fma_command != 16'd1);
                    fma_fifo_reset     <= (fma_command == 16'd1);
                end
            end

            if (wr_en && (addr == `VMPEG_FMV_TCNT)) fmv_timer_compare <= wdata;
            if (wr_en && (addr == `VMPEG_FMV_FRAME_RATE)) fmv_frame_rate <= wdata;

            if (syscmd_wr) begin
                if (wdata[3]) fmv_playback_active <= 1'b1;     // Play
                if (wdata[4]) fmv_playback_active <= 1'b0;     // Pause
                if (wdata[5]) fmv_playback_active <= 1'b1;     // Continue
                if (wdata[8]) begin                            // Clear FIFO
                    fmv_playback_active <= 1'b0;
                    fmv_fifo_reset      <= 1'b1;
                end
                if (wdata[12]) fmv_decoder_enable <= 1'b1;
                if (wdata[13]) begin
                    fmv_decoder_enable  <= 1'b0;
                    fmv_playback_active <= 1'b0;
                end
                if (wdata[15]) begin
                    dma_active  <= 1'b1;
                    dma_for_fma <= 1'b0;
                end
            end
        end
    end

endmodule

/* src/vmpeg_irq_unit.sv */
module vmpeg_irq_unit
    import vmpeg_pkg::*;
#(
    parameter type flag_t = logic [15:0]
) (
    input  logic        clk,
    input  logic        reset,
    input  flag_t       set,
    input  irq_ctl_t    ctl,
    input  logic [15:0] wdata,
    output flag_t       status,
    output flag_t       enable,
    output logic [15:0] vector,
    output logic        intreq
);
    flag_t kept;

    // Flags raised during the clearing read survive it
    assign kept = ctl.clear ? flag_t'('0) : status;

    always_ff @(posedge clk) begin
        if (reset) begin
            status <= '0;
            enable <= '0;
            vector <= '0;
        end else begin
            status <= flag_t'(kept | set);
            if (ctl.ier_write) enable <= flag_t'(wdata);
            if (ctl.ivec_write) vector <= wdata;
        end
    end

    assign intreq = |(status & enable);

endmodule

/* src/vmpeg_pkg.sv */
package vmpeg_pkg;

    typedef struct packed {
        logic [6:0] rsvd_hi;
        logic       poll;       // System timer
        logic [1:0] rsvd_lo;
        logic       err;
        logic       dec;        // Decoding started
        logic       unf;        // Underflow
        logic       upd;        // Frame header updated
        logic       csu;        // Stream changed
        logic       eoi;        // ISO end
    } fma_irq_t;

    typedef struct packed {
        logic erdv;
        logic erdd;
        logic vcup;
        logic pai;      // Pause
        logic vsync;
        logic eii;      // Program end
        logic esi;      // Sequence end
        logic tim;
        logic dcl;
        logic ovf;
        logic ndat;     // No data
        logic rfb;
        logic eod;      // Last picture shown
        logic pic;
        logic gop;
        logic seq;
    } fmv_irq_t;

    typedef struct packed {
        logic [22:0] address;   // Byte address bits [23:1]
        logic [15:0] data;
        logic        uds;
        logic        lds;
        logic        write_strobe;
        logic        cs;
    } bus_req_t;

    // One-cycle pulses from the decoders
    typedef struct packed {
        logic fma_decoding_started;
        logic fma_frame_decoded;
        logic fma_underflow;
        logic fma_program_end;
        logic fmv_first_intra;
        logic fmv_picture;
        logic fmv_last_picture;
        logic fmv_program_end;
        logic fmv_sequence_end;
        logic fmv_underflow;
    } decoder_events_t;

    typedef struct packed {
        logic [7:0] data;
        logic       fmv_valid;
        logic       fma_valid;
    } mpeg_byte_t;

    typedef struct packed {
        logic [15:0] fma_command;
        logic [15:0] fma_status;
        logic [15:0] fmv_timer_compare;
        logic [15:0] fmv_frame_rate;
        logic        dma_active;
        logic        fmv_decoder_enable;
        logic        fmv_playback_active;
    } host_regs_t;

    typedef struct packed {
        logic ier_write;
        logic ivec_write;
        logic clear;        // ISR read
    } irq_ctl_t;

endpackage

/* src/vmpeg_readback.sv */
`include "vmpeg_settings.svh"

module vmpeg_readback
    import vmpeg_pkg::*;
(
    input  logic [`VMPEG_ADDR_W-1:0] address,
    input  logic                     intack,
    input  host_regs_t               regs,
    input  fma_irq_t                 fma_status_irq,
    input  fma_irq_t                 fma_enable,
    input  logic [15:0]              fma_vector,
    input  fmv_irq_t                 fmv_status_irq,
    input  fmv_irq_t                 fmv_enable,
    input  logic [15:0]              fmv_vector,
    input  logic                     fma_intreq,
    input  logic [31:0]              dclk,
    input  logic [15:0]              dclkl_latch,
    output logic [`VMPEG_DATA_W-1:0] dout
);

    always_comb begin
        dout = '0;
        case (address)
            `VMPEG_FMA_CMD:           dout = regs.fma_command;
            `VMPEG_FMA_STAT:          dout = regs.fma_status;
            `VMPEG_FMA_IVEC:          dout = fma_vector;
            `VMPEG_FMA_DCLKH:         dout = dclk[31:16];
            `VMPEG_FMA_DCLKL:         dout = dclkl_latch;     // Captured by DCLKH read
            `VMPEG_FMA_ISR:           dout = fma_status_irq;
            `VMPEG_FMA_IER:           dout = fma_enable;
            `VMPEG_RO_HF2_ADDR:       dout = `VMPEG_RO_HF2;
            `VMPEG_RO_STS_ADDR:       dout = `VMPEG_RO_STS;
            `VMPEG_FMV_IER:           dout = fmv_enable;
            `VMPEG_FMV_ISR:           dout = fmv_status_irq;
            `VMPEG_FMV_TCNT:          dout = regs.fmv_timer_compare;
            `VMPEG_RO_PIC_RATE_ADDR:  dout = `VMPEG_RO_PIC_RATE;
            `VMPEG_RO_DISP_RATE_ADDR: dout = `VMPEG_RO_DISP_RATE;
            `VMPEG_FMV_FRAME_RATE:    dout = regs.fmv_frame_rate;
            `VMPEG_FMV_IVEC:          dout = fmv_vector;
            default: ;
        endcase

        // Vectored acknowledge with FMA first
        if (intack) begin
            if (fma_intreq) begin
                dout = {fma_vector[7:0], fma_vector[7:0]};
            end else begin
                dout = {fmv_vector[10:3], fmv_vector[10:3]};
            end
        end
    end

endmodule

/* src/vmpeg_settings.svh */
`ifndef VMPEG_SETTINGS_SVH
`define VMPEG_SETTINGS_SVH

`define VMPEG_ADDR_W 15                  // Word address bits [15:1]
`define VMPEG_DATA_W 16

// FMA register word addresses
`define VMPEG_FMA_CMD 15'h1800
`define VMPEG_FMA_STAT 15'h1801
`define VMPEG_FMA_IVEC 15'h1806
`define VMPEG_FMA_DCLKH 15'h1808
`define VMPEG_FMA_DCLKL 15'h1809
`define VMPEG_FMA_ISR 15'h180D
`define VMPEG_FMA_IER 15'h180E

// FMV register word addresses
`define VMPEG_FMV_IER 15'h2030
`define VMPEG_FMV_ISR 15'h2031
`define VMPEG_FMV_TCNT 15'h2032
`define VMPEG_FMV_FRAME_RATE 15'h2056
`define VMPEG_FMV_TRLD 15'h2057
`define VMPEG_FMV_SYSCMD 15'h2060
`define VMPEG_FMV_IVEC 15'h206E
`define VMPEG_FMV_XFER 15'h206F

`define VMPEG_TCNT_RESET 16'd55          // 10 ms period
`define VMPEG_TIMER_FRAC 3

// Constant readback registers
`define VMPEG_RO_HF2_ADDR 15'h1812
`define VMPEG_RO_HF2 16'h0004            // DSP HF2 flag
`define VMPEG_RO_PIC_RATE_ADDR 15'h2054
`define VMPEG_RO_PIC_RATE 16'h0E10       // 25 fps
`define VMPEG_RO_DISP_RATE_ADDR 15'h2055
`define VMPEG_RO_DISP_RATE 16'h0708
`define VMPEG_RO_STS_ADDR 15'h202F
`define VMPEG_RO_STS 16'h2000

`endif

/* src/vmpeg_timebase.sv */
`include "vmpeg_settings.svh"

module vmpeg_timebase
    import vmpeg_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        clk45tick,
    input  logic [15:0] tcnt,
    input  logic        trld_clear,
    input  logic        dclk_latch,
    output logic [31:0] dclk,
    output logic [15:0] dclkl_latch,
    output logic        timer_fire
);
    localparam int CNT_W = 16 + `VMPEG_TIMER_FRAC + 2;

    logic [CNT_W-1:0] timer_cnt;
    wire  [CNT_W-`VMPEG_TIMER_FRAC-1:0] timer_int = timer_cnt[CNT_W-1:`VMPEG_TIMER_FRAC];

    // Integer part reached the compare value
    assign timer_fire = clk45tick && (timer_int >= tcnt);

    always_ff @(posedge clk) begin
        if (reset) begin
            dclk        <= '0;
            dclkl_latch <= '0;
            timer_cnt   <= '0;
        end else begin
            if (clk45tick) begin
                dclk <= dclk + 32'd1;
                if (timer_fire) begin
                    timer_cnt <= '0;
                end else begin
                    timer_cnt <= timer_cnt + 1'b1;
                end
            end
            if (trld_clear) timer_cnt <= '0;   // Re-arm
            if (dclk_latch) dclkl_latch <= dclk[15:0];
        end
    end

endmodule

/* src/vmpeg_top.sv */
module vmpeg_top (
    input  logic                       clk,
    input  logic                       reset,
    input  vmpeg_pkg::bus_req_t        bus,
    output logic [15:0]                dout,
    output logic                       bus_ack,
    input  logic                       intack,
    output logic                       intreq,
    output logic                       req,
    output logic                       rdy,
    input  logic                       ack,
    input  logic                       dtc,
    input  logic                       done_in,
    input  logic                       vsync,
    input  logic                       clk45tick,
    input  vmpeg_pkg::decoder_events_t events,
    output vmpeg_pkg::mpeg_byte_t      mpeg_byte,
    output logic                       fma_decoder_enable,
    output logic                       fma_fifo_reset,
    output logic                       fmv_decoder_enable,
    output logic                       fmv_playback_active,
    output logic                       fmv_fifo_reset
);
    vmpeg_pkg::host_regs_t regs;
    vmpeg_pkg::irq_ctl_t   fma_irq_ctl;
    vmpeg_pkg::irq_ctl_t   fmv_irq_ctl;
    vmpeg_pkg::fma_irq_t   fma_set;
    vmpeg_pkg::fma_irq_t   fma_status;
    vmpeg_pkg::fma_irq_t   fma_enable;
    vmpeg_pkg::fmv_irq_t   fmv_set;
    vmpeg_pkg::fmv_irq_t   fmv_status;
    vmpeg_pkg::fmv_irq_t   fmv_enable;
    logic [15:0]           fma_vector;
    logic [15:0]           fmv_vector;
    logic                  fma_intreq;
    logic                  fmv_intreq;
    logic                  trld_clear;
    logic                  dclk_latch;
    logic                  xfer_write;
    logic                  dma_for_fma;
    logic                  timer_fire;
    logic [31:0]           dclk;
    logic [15:0]           dclkl_latch;

    assign intreq              = fma_intreq || fmv_intreq;
    assign req                 = regs.dma_active;
    assign rdy                 = regs.dma_active;
    assign fmv_decoder_enable  = regs.fmv_decoder_enable;
    assign fmv_playback_active = regs.fmv_playback_active;

    vmpeg_host_ctrl host_ctrl_i (
        .clk, .reset, .bus, .ack, .done_in, .vsync, .events, .timer_fire,
        .bus_ack, .fma_irq_ctl, .fmv_irq_ctl, .fma_set, .fmv_set, .regs,
        .trld_clear, .dclk_latch, .xfer_write, .dma_for_fma,
        .fma_decoder_enable, .fma_fifo_reset, .fmv_fifo_reset
    );

    vmpeg_irq_unit #(.flag_t(vmpeg_pkg::fma_irq_t)) fma_irq_i (
        .clk, .reset, .set(fma_set), .ctl(fma_irq_ctl), .wdata(bus.data),
        .status(fma_status), .enable(fma_enable), .vector(fma_vector), .intreq(fma_intreq)
    );

    vmpeg_irq_unit #(.flag_t(vmpeg_pkg::fmv_irq_t)) fmv_irq_i (
        .clk, .reset, .set(fmv_set), .ctl(fmv_irq_ctl), .wdata(bus.data),
        .status(fmv_status), .enable(fmv_enable), .vector(fmv_vector), .intreq(fmv_intreq)
    );

    vmpeg_timebase timebase_i (
        .clk, .reset, .clk45tick, .tcnt(regs.fmv_timer_compare), .trld_clear,
        .dclk_latch, .dclk, .dclkl_latch, .timer_fire
    );

    vmpeg_byte_splitter byte_splitter_i (
        .clk, .reset, .din(bus.data), .ack, .dtc, .xfer_write, .dma_for_fma, .mpeg_byte
    );

    vmpeg_readback readback_i (
        .address(bus.address[14:0]), .intack, .regs,
        .fma_status_irq(fma_status), .fma_enable, .fma_vector,
        .fmv_status_irq(fmv_status), .fmv_enable, .fmv_vector,
        .fma_intreq, .dclk, .dclkl_latch, .dout
    );

endmodule

/* vlog.f */
+incdir+src
+incdir+bench
src/vmpeg_pkg.sv
src/vmpeg_host_ctrl.sv
src/vmpeg_irq_unit.sv
src/vmpeg_timebase.sv
src/vmpeg_byte_splitter.sv
src/vmpeg_readback.sv
src/vmpeg_top.sv
bench/vmpeg_tb.sv
